// File: source/l2_cache_pkg.sv
/* L2 cache shared definitions
   Address fields, data widths, MESI states and controller states
*/
package l2_cache_pkg;

  // L1 side address and data
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // One memory beat carries two cache words
  typedef logic [63:0] beat_t;

  // Address fields
  typedef logic [21:0] tag_t;
  typedef logic [3:0]  index_t;
  typedef logic [3:0]  word_idx_t;

  typedef logic [1:0]  way_t;
  typedef logic [2:0]  beat_idx_t;

  // Tree pseudo-LRU, bit 2 is the root
  typedef logic [2:0]  plru_t;

  // Bit 1 low means a plain L1 access
  typedef logic [1:0]  snoop_t;

  typedef enum logic [1:0] {
    INVALID   = 2'b00,
    EXCLUSIVE = 2'b01,
    SHARED    = 2'b10,
    MODIFIED  = 2'b11
  } mesi_t;

  // Request FSM states
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    LOOKUP = 2'b01,
    FILL   = 2'b10,
    FINISH = 2'b11
  } ctrl_state_t;

  // Geometry
  localparam int NUM_WAYS       = 4;
  localparam int NUM_SETS       = 16;
  localparam int BURST_LEN      = 8;
  localparam int WORDS_PER_LINE = 16;

  // Address bit positions
  localparam int TAG_MSB  = 31;
  localparam int TAG_LSB  = 10;
  localparam int IDX_MSB  = 9;
  localparam int IDX_LSB  = 6;
  localparam int WORD_MSB = 5;
  localparam int WORD_LSB = 2;

  // Snoop codes
  localparam snoop_t SNOOP_READ  = 2'b10;
  localparam snoop_t SNOOP_WRITE = 2'b11;

endpackage

// File: source/l2_tag_store.sv
`timescale 1ns/1ps
/* L2 tag store
   Tags, MESI state and tree pseudo-LRU per set, hit lookup and victim choice
*/
module l2_tag_store (
  input  logic                 stb,
  input  logic                 stb_n,
  input  l2_cache_pkg::index_t idx,
  input  l2_cache_pkg::tag_t   tag,
  input  logic                 upd_en,
  input  l2_cache_pkg::way_t   upd_way,
  input  l2_cache_pkg::tag_t   upd_tag,
  input  l2_cache_pkg::mesi_t  upd_mesi,
  input  logic                 plru_touch,
  output logic                 hit,
  output l2_cache_pkg::way_t   hit_way,
  output l2_cache_pkg::way_t   victim_way
);

  l2_cache_pkg::tag_t  tags [l2_cache_pkg::NUM_SETS][l2_cache_pkg::NUM_WAYS];
  l2_cache_pkg::mesi_t mesi [l2_cache_pkg::NUM_SETS][l2_cache_pkg::NUM_WAYS];
  l2_cache_pkg::plru_t plru [l2_cache_pkg::NUM_SETS];

  logic [l2_cache_pkg::NUM_WAYS-1:0] match;
  logic [l2_cache_pkg::NUM_WAYS-1:0] is_invalid;
  l2_cache_pkg::plru_t               cur_plru;

  assign cur_plru = plru[idx];

  // Per-way compare, an INVALID way never hits
  always_comb
  begin
    for (int w = 0; w < l2_cache_pkg::NUM_WAYS; w++)
    begin
      is_invalid[w] = (mesi[idx][w] == l2_cache_pkg::INVALID);
      match[w]      = !is_invalid[w] && (tags[idx][w] == tag);
    end
  end

  assign hit = |match;

  // Encode the matching way
  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < l2_cache_pkg::NUM_WAYS; w++)
    begin
      if (match[w])
        hit_way = l2_cache_pkg::way_t'(w);
    end
  end

  // Lowest INVALID way first, else walk the tree
  always_comb
  begin
    if (!cur_plru[2])
      victim_way = cur_plru[1] ? 2'd1 : 2'd0;
    else
      victim_way = cur_plru[0] ? 2'd3 : 2'd2;
    // Downward scan so the lowest free way wins
    for (int w = l2_cache_pkg::NUM_WAYS - 1; w >= 0; w--)
    begin
      if (is_invalid[w])
        victim_way = l2_cache_pkg::way_t'(w);
    end
  end

  // MESI state and tree bits
  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      for (int s = 0; s < l2_cache_pkg::NUM_SETS; s++)
      begin
        plru[s] <= '0;
        for (int w = 0; w < l2_cache_pkg::NUM_WAYS; w++)
          mesi[s][w] <= l2_cache_pkg::INVALID;
      end
    end
    else
    begin
      if (upd_en)
        mesi[idx][upd_way] <= upd_mesi;
      // Point the path away from the way just used
      if (plru_touch)
      begin
        case (upd_way)
          2'd0:
          begin
            plru[idx][2] <= 1'b1;
            plru[idx][1] <= 1'b1;
          end
          2'd1:
          begin
            plru[idx][2] <= 1'b1;
            plru[idx][1] <= 1'b0;
          end
          2'd2:
          begin
            plru[idx][2] <= 1'b0;
            plru[idx][0] <= 1'b1;
          end
          default:
          begin
            plru[idx][2] <= 1'b0;
            plru[idx][0] <= 1'b0;
          end
        endcase
      end
    end
  end

  // Tag array
  always_ff @(posedge stb)
  begin
    if (upd_en)
      tags[idx][upd_way] <= upd_tag;
  end

  // A line is never held by two ways of a set
  a_one_match: assert property (@(posedge stb) disable iff (!stb_n) $onehot0(match));

endmodule

// File: source/l2_data_store.sv
`timescale 1ns/1ps
/* L2 data store
   Line data in even and odd word banks, beat fill, word write and word read
*/
module l2_data_store (
  input  logic                    stb,
  input  l2_cache_pkg::index_t    idx,
  input  l2_cache_pkg::way_t      way,
  input  l2_cache_pkg::word_idx_t word,
  input  logic                    wr_en,
  input  l2_cache_pkg::word_t     wdata,
  input  logic                    beat_we,
  input  l2_cache_pkg::beat_idx_t beat_idx,
  input  l2_cache_pkg::beat_t     mem_rdata,
  output l2_cache_pkg::word_t     rd_data
);

  localparam int BANK_DEPTH = l2_cache_pkg::WORDS_PER_LINE / 2;

  // Even words in one bank, odd words in the other
  l2_cache_pkg::word_t even_bank [l2_cache_pkg::NUM_SETS][l2_cache_pkg::NUM_WAYS][BANK_DEPTH];
  l2_cache_pkg::word_t odd_bank  [l2_cache_pkg::NUM_SETS][l2_cache_pkg::NUM_WAYS][BANK_DEPTH];

  l2_cache_pkg::beat_idx_t word_row;
  l2_cache_pkg::beat_idx_t wr_row;

  // Word pair holding the addressed word
  assign word_row = word[3:1];

  // A beat and a word write never overlap
  assign wr_row = beat_we ? beat_idx : word_row;

  always_ff @(posedge stb)
  begin
    // Low half of a beat is the even word
    if (beat_we || (wr_en && !word[0]))
      even_bank[idx][way][wr_row] <= beat_we ? mem_rdata[31:0] : wdata;
    if (beat_we || (wr_en && word[0]))
      odd_bank[idx][way][wr_row] <= beat_we ? mem_rdata[63:32] : wdata;
  end

  // Registered read
  always_ff @(posedge stb)
  begin
    if (word[0])
      rd_data <= odd_bank[idx][way][word_row];
    else
      rd_data <= even_bank[idx][way][word_row];
  end

endmodule

// File: source/l2_line_fill.sv
`timescale 1ns/1ps
/* L2 line fill
   Requests a line from memory and counts the eight returning beats
*/
module l2_line_fill (
  input  logic                    stb,
  input  logic                    stb_n,
  input  logic                    fill_start,
  input  logic                    mem_rvalid,
  output logic                    mem_req,
  output logic                    beat_we,
  output l2_cache_pkg::beat_idx_t beat_idx,
  output logic                    fill_done
);

  localparam l2_cache_pkg::beat_idx_t LAST_BEAT =
    l2_cache_pkg::beat_idx_t'(l2_cache_pkg::BURST_LEN - 1);

  // Burst in flight
  logic fill_open;

  // Beats always accepted
  assign beat_we   = mem_rvalid && fill_open;
  assign fill_done = beat_we && (beat_idx == LAST_BEAT);

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      mem_req   <= 1'b0;
      fill_open <= 1'b0;
      beat_idx  <= '0;
    end
    else
    begin
      // Request goes out one cycle after the start pulse
      mem_req <= fill_start;
      if (fill_start)
      begin
        fill_open <= 1'b1;
        beat_idx  <= '0;
      end
      else if (fill_done)
        fill_open <= 1'b0;
      if (beat_we)
        beat_idx <= beat_idx + 1'b1;
    end
  end

  // Memory only returns data for a requested line
  a_beat_in_fill: assert property (@(posedge stb) disable iff (!stb_n)
    mem_rvalid |-> fill_open);

endmodule

// File: source/l2_req_ctrl.sv
`timescale 1ns/1ps
/* L2 request controller
   FSM serving L1 reads and writes and applying snooped MESI changes
*/
module l2_req_ctrl (
  input  logic                    stb,
  input  logic                    stb_n,
  input  logic                    l1_req,
  input  logic                    l1_we,
  input  l2_cache_pkg::snoop_t    snoop,
  input  l2_cache_pkg::addr_t     l1_addr,
  input  l2_cache_pkg::word_t     l1_wdata,
  input  logic                    hit,
  input  l2_cache_pkg::way_t      hit_way,
  input  l2_cache_pkg::way_t      victim_way,
  input  logic                    fill_done,
  output logic                    stall,
  output logic                    inv,
  output l2_cache_pkg::addr_t     mem_addr,
  output logic                    fill_start,
  output l2_cache_pkg::index_t    idx,
  output l2_cache_pkg::tag_t      tag,
  output logic                    upd_en,
  output l2_cache_pkg::way_t      upd_way,
  output l2_cache_pkg::tag_t      upd_tag,
  output l2_cache_pkg::mesi_t     upd_mesi,
  output logic                    plru_touch,
  output l2_cache_pkg::way_t      way,
  output l2_cache_pkg::word_idx_t word,
  output logic                    wr_en,
  output l2_cache_pkg::word_t     wdata
);

  l2_cache_pkg::ctrl_state_t state;
  l2_cache_pkg::ctrl_state_t state_nxt;

  // Registered request
  logic                 we_q;
  l2_cache_pkg::snoop_t snoop_q;
  logic                 hit_q;

  logic req_take;
  logic is_snoop;
  logic in_finish;

  assign req_take  = (state == l2_cache_pkg::IDLE) && l1_req;
  assign is_snoop  = snoop_q[1];
  assign in_finish = (state == l2_cache_pkg::FINISH);

  // Busy from LOOKUP until back in IDLE
  assign stall = (state != l2_cache_pkg::IDLE);

  // L1 access that missed
  assign fill_start = (state == l2_cache_pkg::LOOKUP) && !is_snoop && !hit;

  // Line-aligned fill address
  assign mem_addr = {tag, idx, {l2_cache_pkg::IDX_LSB{1'b0}}};

  always_comb
  begin
    state_nxt = state;
    unique case (state)
      l2_cache_pkg::IDLE:
        if (l1_req)
          state_nxt = l2_cache_pkg::LOOKUP;
      l2_cache_pkg::LOOKUP:
        // Only L1 misses go to memory
        state_nxt = fill_start ? l2_cache_pkg::FILL : l2_cache_pkg::FINISH;
      l2_cache_pkg::FILL:
        if (fill_done)
          state_nxt = l2_cache_pkg::FINISH;
      l2_cache_pkg::FINISH:
        state_nxt = l2_cache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      state   <= l2_cache_pkg::IDLE;
      inv     <= 1'b0;
      tag     <= '0;
      idx     <= '0;
      word    <= '0;
      we_q    <= 1'b0;
      snoop_q <= '0;
      hit_q   <= 1'b0;
      way     <= '0;
    end
    else
    begin
      state <= state_nxt;
      // Lands in the cycle stall falls
      inv <= in_finish && we_q && !is_snoop;
      // Address decode
      if (req_take)
      begin
        tag     <= l1_addr[l2_cache_pkg::TAG_MSB:l2_cache_pkg::TAG_LSB];
        idx     <= l1_addr[l2_cache_pkg::IDX_MSB:l2_cache_pkg::IDX_LSB];
        word    <= l1_addr[l2_cache_pkg::WORD_MSB:l2_cache_pkg::WORD_LSB];
        we_q    <= l1_we;
        snoop_q <= snoop;
      end
      // Victim way on an L1 miss, matching way otherwise
      if (state == l2_cache_pkg::LOOKUP)
      begin
        hit_q <= hit;
        way   <= (hit || is_snoop) ? hit_way : victim_way;
      end
    end
  end

  // Write data
  always_ff @(posedge stb)
  begin
    if (req_take)
      wdata <= l1_wdata;
  end

  // Word write after any fill
  assign wr_en = in_finish && we_q && !is_snoop;

  // Read hits keep their state
  assign upd_en = in_finish && (is_snoop ? hit_q : (we_q || !hit_q));
  assign upd_way = way;
  assign upd_tag = tag;

  // Snoops leave the replacement order alone
  assign plru_touch = in_finish && !is_snoop;

  always_comb
  begin
    if (snoop_q == l2_cache_pkg::SNOOP_WRITE)
      upd_mesi = l2_cache_pkg::INVALID;
    else if (snoop_q == l2_cache_pkg::SNOOP_READ)
      upd_mesi = l2_cache_pkg::SHARED;
    else if (we_q)
      upd_mesi = l2_cache_pkg::MODIFIED;
    else
      upd_mesi = l2_cache_pkg::EXCLUSIVE;
  end

  // L1 waits for stall to drop
  a_req_idle: assert property (@(posedge stb) disable iff (!stb_n)
    l1_req |-> !stall);

  // A read or a snoop ends without an invalidate
  a_no_inv_read: assert property (@(posedge stb) disable iff (!stb_n)
    (req_take && !(l1_we && !snoop[1])) |=> (!inv until_with !stall));

endmodule

// File: source/l2_cache_top.sv
`timescale 1ns/1ps
/* L2 cache top level
   Four-way MESI L2 with the request FSM, tag and data stores and line fill
*/
module l2_cache_top (
  input  logic                 stb,
  input  logic                 stb_n,
  input  logic                 l1_req,
  input  logic                 l1_we,
  input  l2_cache_pkg::snoop_t snoop,
  input  l2_cache_pkg::addr_t  l1_addr,
  input  l2_cache_pkg::word_t  l1_wdata,
  input  l2_cache_pkg::beat_t  mem_rdata,
  input  logic                 mem_rvalid,
  output logic                 stall,
  output logic                 inv,
  output l2_cache_pkg::word_t  l1_rdata,
  output logic                 mem_req,
  output l2_cache_pkg::addr_t  mem_addr
);

  // Lookup
  l2_cache_pkg::index_t idx;
  l2_cache_pkg::tag_t   tag;
  logic                 hit;
  l2_cache_pkg::way_t   hit_way;
  l2_cache_pkg::way_t   victim_way;

  // Tag and state update
  logic                 upd_en;
  l2_cache_pkg::way_t   upd_way;
  l2_cache_pkg::tag_t   upd_tag;
  l2_cache_pkg::mesi_t  upd_mesi;
  logic                 plru_touch;

  // Data access
  l2_cache_pkg::way_t      way;
  l2_cache_pkg::word_idx_t word;
  logic                    wr_en;
  l2_cache_pkg::word_t     wdata;

  // Fill
  logic                    fill_start;
  logic                    fill_done;
  logic                    beat_we;
  l2_cache_pkg::beat_idx_t beat_idx;

  l2_req_ctrl i_req_ctrl (
    .stb        (stb),
    .stb_n      (stb_n),
    .l1_req     (l1_req),
    .l1_we      (l1_we),
    .snoop      (snoop),
    .l1_addr    (l1_addr),
    .l1_wdata   (l1_wdata),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way),
    .fill_done  (fill_done),
    .stall      (stall),
    .inv        (inv),
    .mem_addr   (mem_addr),
    .fill_start (fill_start),
    .idx        (idx),
    .tag        (tag),
    .upd_en     (upd_en),
    .upd_way    (upd_way),
    .upd_tag    (upd_tag),
    .upd_mesi   (upd_mesi),
    .plru_touch (plru_touch),
    .way        (way),
    .word       (word),
    .wr_en      (wr_en),
    .wdata      (wdata)
  );

  l2_tag_store i_tag_store (
    .stb        (stb),
    .stb_n      (stb_n),
    .idx        (idx),
    .tag        (tag),
    .upd_en     (upd_en),
    .upd_way    (upd_way),
    .upd_tag    (upd_tag),
    .upd_mesi   (upd_mesi),
    .plru_touch (plru_touch),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  l2_data_store i_data_store (
    .stb       (stb),
    .idx       (idx),
    .way       (way),
    .word      (word),
    .wr_en     (wr_en),
    .wdata     (wdata),
    .beat_we   (beat_we),
    .beat_idx  (beat_idx),
    .mem_rdata (mem_rdata),
    .rd_data   (l1_rdata)
  );

  l2_line_fill i_line_fill (
    .stb        (stb),
    .stb_n      (stb_n),
    .fill_start (fill_start),
    .mem_rvalid (mem_rvalid),
    .mem_req    (mem_req),
    .beat_we    (beat_we),
    .beat_idx   (beat_idx),
    .fill_done  (fill_done)
  );

endmodule

// File: tests/l2_cache_model.svh
/* L2 cache reference model
   MESI, victim and pseudo-LRU rules, memory contents and result compares
*/
`ifndef L2_CACHE_MODEL_SVH
`define L2_CACHE_MODEL_SVH

// Model state per set and way
l2_cache_pkg::tag_t  m_tag  [l2_cache_pkg::NUM_SETS][l2_cache_pkg::NUM_WAYS];
l2_cache_pkg::mesi_t m_mesi [l2_cache_pkg::NUM_SETS][l2_cache_pkg::NUM_WAYS];
l2_cache_pkg::plru_t m_plru [l2_cache_pkg::NUM_SETS];
l2_cache_pkg::word_t m_data [l2_cache_pkg::NUM_SETS][l2_cache_pkg::NUM_WAYS]
                            [l2_cache_pkg::WORDS_PER_LINE];

// Memory is never written, each word is fixed by its address
function automatic l2_cache_pkg::word_t mem_word(input l2_cache_pkg::addr_t line_addr,
                                                 input int w);
  l2_cache_pkg::addr_t a;
  a = line_addr | l2_cache_pkg::addr_t'(w * 4);
  return {a[15:0], ~a[31:16]} ^ 32'h6B2D_93E1;
endfunction

// Even word in the low half
function automatic l2_cache_pkg::beat_t beat_data(input l2_cache_pkg::addr_t line_addr,
                                                  input int b);
  return {mem_word(line_addr, 2 * b + 1), mem_word(line_addr, 2 * b)};
endfunction

task automatic model_reset();
  for (int s = 0; s < l2_cache_pkg::NUM_SETS; s++)
  begin
    m_plru[s] = '0;
    for (int w = 0; w < l2_cache_pkg::NUM_WAYS; w++)
      m_mesi[s][w] = l2_cache_pkg::INVALID;
  end
endtask

// First free way, else follow the tree
function automatic int model_victim(input int s);
  l2_cache_pkg::plru_t p;
  p = m_plru[s];
  for (int w = 0; w < l2_cache_pkg::NUM_WAYS; w++)
  begin
    if (m_mesi[s][w] == l2_cache_pkg::INVALID)
      return w;
  end
  if (p[2])
    return p[0] ? 3 : 2;
  return p[1] ? 1 : 0;
endfunction

// Root and leaf bit point to the other side
task automatic model_touch(input int s, input int w);
  if (w < 2)
  begin
    m_plru[s][2] = 1'b1;
    m_plru[s][1] = (w == 0);
  end
  else
  begin
    m_plru[s][2] = 1'b0;
    m_plru[s][0] = (w == 2);
  end
endtask

task automatic model_access(input l2_cache_pkg::addr_t addr, input logic we,
                            input l2_cache_pkg::snoop_t sn, input l2_cache_pkg::word_t wd,
                            output logic miss, output l2_cache_pkg::word_t rdata);
  int                  s;
  int                  wi;
  int                  way;
  logic                found;
  l2_cache_pkg::tag_t  t;
  l2_cache_pkg::addr_t line;
  s     = addr[l2_cache_pkg::IDX_MSB:l2_cache_pkg::IDX_LSB];
  wi    = addr[l2_cache_pkg::WORD_MSB:l2_cache_pkg::WORD_LSB];
  t     = addr[l2_cache_pkg::TAG_MSB:l2_cache_pkg::TAG_LSB];
  line  = {addr[31:6], 6'b0};
  found = 1'b0;
  way   = 0;
  miss  = 1'b0;
  rdata = '0;
  for (int w = 0; w < l2_cache_pkg::NUM_WAYS; w++)
  begin
    if (m_mesi[s][w] != l2_cache_pkg::INVALID && m_tag[s][w] == t)
    begin
      found = 1'b1;
      way   = w;
    end
  end
  if (sn[1])
  begin
    // Snoops change state only, no fill and no LRU update
    if (found)
      m_mesi[s][way] = (sn == l2_cache_pkg::SNOOP_WRITE) ? l2_cache_pkg::INVALID
                                                         : l2_cache_pkg::SHARED;
  end
  else
  begin
    if (!found)
    begin
      // Write-allocate, old contents dropped
      miss          = 1'b1;
      way           = model_victim(s);
      m_tag[s][way] = t;
      for (int i = 0; i < l2_cache_pkg::WORDS_PER_LINE; i++)
        m_data[s][way][i] = mem_word(line, i);
      m_mesi[s][way] = l2_cache_pkg::EXCLUSIVE;
    end
    if (we)
    begin
      m_data[s][way][wi] = wd;
      m_mesi[s][way]     = l2_cache_pkg::MODIFIED;
    end
    rdata = m_data[s][way][wi];
    model_touch(s, way);
  end
endtask

task automatic check_word(input l2_cache_pkg::word_t got, input l2_cache_pkg::word_t exp,
                          input string what);
  if (got !== exp)
    abort_run($sformatf("[FAIL] %0d ns %s: got %h, expected %h", $time, what, got, exp));
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp)
    abort_run($sformatf("[FAIL] %0d ns %s: got %b, expected %b", $time, what, got, exp));
endtask

`endif

// File: tests/tb_l2_cache.sv
`timescale 1ns/1ps
/* L2 cache testbench
   Random L1 and snoop traffic checked against a reference model, with a memory responder
*/
module tb_l2_cache;

  localparam int  NUM_REQS     = 400;
  localparam int  RESET_CYCLES = 5;
  localparam int  CYCLE_LIMIT  = RESET_CYCLES + NUM_REQS * 50;
  localparam time DRIVE_DLY    = 2;

  logic                 stb = 1'b0;
  logic                 stb_n;
  logic                 l1_req;
  logic                 l1_we;
  l2_cache_pkg::snoop_t snoop;
  l2_cache_pkg::addr_t  l1_addr;
  l2_cache_pkg::word_t  l1_wdata;
  l2_cache_pkg::beat_t  mem_rdata;
  logic                 mem_rvalid;
  logic                 stall;
  logic                 inv;
  l2_cache_pkg::word_t  l1_rdata;
  logic                 mem_req;
  l2_cache_pkg::addr_t  mem_addr;

  // Separate generators for requests and beat gaps
  logic [15:0] stim_lfsr;
  logic [15:0] mem_lfsr;
  int          cycles = 0;

  always #10 stb = ~stb;

  l2_cache_top i_dut (
    .stb        (stb),
    .stb_n      (stb_n),
    .l1_req     (l1_req),
    .l1_we      (l1_we),
    .snoop      (snoop),
    .l1_addr    (l1_addr),
    .l1_wdata   (l1_wdata),
    .mem_rdata  (mem_rdata),
    .mem_rvalid (mem_rvalid),
    .stall      (stall),
    .inv        (inv),
    .l1_rdata   (l1_rdata),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "run stopped at first error");
  endtask

`include "l2_cache_model.svh"

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One step per bit taken
  task automatic draw_bits(inout logic [15:0] state, input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      state = lfsr_next(state);
      val   = {val[30:0], state[0]};
    end
  endtask

  // Eight beats, each after a gap of 0 to 3 cycles
  task automatic serve_fill();
    logic [31:0] gap;
    for (int b = 0; b < l2_cache_pkg::BURST_LEN; b++)
    begin
      draw_bits(mem_lfsr, 2, gap);
      repeat (gap)
      begin
        @(posedge stb);
        #DRIVE_DLY;
      end
      mem_rvalid = 1'b1;
      mem_rdata  = beat_data(mem_addr, b);
      @(posedge stb);
      #DRIVE_DLY;
      mem_rvalid = 1'b0;
    end
  endtask

  // Memory responder
  always
  begin
    @(posedge stb);
    #DRIVE_DLY;
    if (mem_req)
      serve_fill();
  end

  // Issue one request, watch it until stall drops, then compare
  task automatic run_request(input l2_cache_pkg::addr_t addr, input logic we,
                             input l2_cache_pkg::snoop_t sn, input l2_cache_pkg::word_t wd);
    logic                exp_miss;
    l2_cache_pkg::word_t exp_rdata;
    logic                is_l1;
    int                  stall_cnt;
    int                  req_cnt;
    int                  inv_cnt;
    is_l1 = !sn[1];
    model_access(addr, we, sn, wd, exp_miss, exp_rdata);
    l1_req    = 1'b1;
    l1_we     = we;
    snoop     = sn;
    l1_addr   = addr;
    l1_wdata  = wd;
    stall_cnt = 0;
    req_cnt   = 0;
    inv_cnt   = 0;
    do
    begin
      @(posedge stb);
      #DRIVE_DLY;
      l1_req = 1'b0;
      if (stall)
        stall_cnt++;
      if (mem_req)
        req_cnt++;
      if (inv)
        inv_cnt++;
    end
    while (stall);
    check_bit(req_cnt != 0, exp_miss, $sformatf("memory request for %h", addr));
    check_bit(req_cnt > 1, 1'b0, "repeated memory request");
    check_bit(inv_cnt != 0, is_l1 && we, $sformatf("invalidate pulse for %h", addr));
    check_bit(inv_cnt > 1, 1'b0, "repeated invalidate pulse");
    // Hits and snoops take exactly LOOKUP and FINISH
    check_bit(stall_cnt == 2, !exp_miss, "two-cycle stall");
    if (is_l1 && !we)
      check_word(l1_rdata, exp_rdata, $sformatf("read data at %h", addr));
  endtask

  // Cycle limit
  always @(posedge stb)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
      abort_run($sformatf("Timeout after %0d cycles, a request never completed", cycles));
  end

  initial
  begin
    logic [31:0]          op;
    logic [31:0]          tsel;
    logic [31:0]          ssel;
    logic [31:0]          wsel;
    logic [31:0]          wd;
    logic                 we;
    l2_cache_pkg::snoop_t sn;
    l2_cache_pkg::addr_t  addr;
    stb_n      = 1'b0;
    l1_req     = 1'b0;
    l1_we      = 1'b0;
    snoop      = '0;
    l1_addr    = '0;
    l1_wdata   = '0;
    mem_rdata  = '0;
    mem_rvalid = 1'b0;
    stim_lfsr  = 16'd40;
    mem_lfsr   = 16'd40;
    model_reset();
    repeat (RESET_CYCLES) @(posedge stb);
    #DRIVE_DLY;
    stb_n = 1'b1;
    @(posedge stb);
    #DRIVE_DLY;
    for (int n = 0; n < NUM_REQS; n++)
    begin
      draw_bits(stim_lfsr, 3, op);
      draw_bits(stim_lfsr, 3, tsel);
      draw_bits(stim_lfsr, 2, ssel);
      draw_bits(stim_lfsr, 6, wsel);
      draw_bits(stim_lfsr, 32, wd);
      // Eight tags over four sets, so lines get evicted and hit again
      addr = {19'h5A3C5, tsel[2:0], ssel[1:0], 2'b10, wsel[5:0]};
      // Reads 4/8, writes 2/8, snoop read and snoop write 1/8 each
      if (op[2:0] == 3'd7)
        sn = l2_cache_pkg::SNOOP_WRITE;
      else if (op[2:0] == 3'd6)
        sn = l2_cache_pkg::SNOOP_READ;
      else
        sn = {1'b0, wd[31]};
      we = (op[2:1] == 2'b10) || (op[2:1] == 2'b11 && wd[0]);
      run_request(addr, we, sn, wd);
    end
    $display("Completed %0d requests in %0d cycles", NUM_REQS, cycles);
    $display("** PASS **");
    $finish;
  end

endmodule

// File: list.f
+incdir+tests
source/l2_cache_pkg.sv
source/l2_tag_store.sv
source/l2_data_store.sv
source/l2_line_fill.sv
source/l2_req_ctrl.sv
source/l2_cache_top.sv
tests/tb_l2_cache.sv
